/* hw/level/level_layout.svh */
// Seven hard-coded platform layouts, one case item per block index
// x and y are relative to the segment, length is in 8-pixel units

`ifndef LEVEL_LAYOUT_SVH
`define LEVEL_LAYOUT_SVH

// Wide starter platforms, nothing below 60
3'd0: begin
    lay_x   = '{280, 100, 350, 50, 300, 150, 400};
    lay_y   = '{60, 80, 140, 200, 260, 320, 380};
    lay_len = '{10, 8, 8, 8, 8, 8, 8};
end

// Alternating left and right
3'd1: begin
    lay_x   = '{450, 50, 400, 100, 350, 150, 450};
    lay_y   = '{10, 70, 130, 190, 250, 310, 370};
    lay_len = '{5, 5, 5, 5, 5, 5, 5};
end

// Staircase
3'd2: begin
    lay_x   = '{300, 200, 100, 300, 200, 100, 300};
    lay_y   = '{15, 75, 135, 195, 255, 315, 375};
    lay_len = '{6, 6, 6, 6, 6, 6, 6};
end

// Dense on the right side
3'd3: begin
    lay_x   = '{400, 350, 400, 350, 400, 350, 400};
    lay_y   = '{20, 80, 140, 200, 260, 320, 380};
    lay_len = '{8, 8, 8, 8, 8, 8, 8};
end

// Dense on the left side
3'd4: begin
    lay_x   = '{50, 100, 50, 100, 50, 100, 50};
    lay_y   = '{20, 80, 140, 200, 260, 320, 380};
    lay_len = '{8, 8, 8, 5, 10, 5, 8};
end

// Wide and narrow mixed
3'd5: begin
    lay_x   = '{400, 100, 350, 150, 300, 200, 400};
    lay_y   = '{15, 75, 135, 195, 255, 315, 375};
    lay_len = '{10, 10, 10, 8, 8, 8, 10};
end

// Long zigzag
3'd6: begin
    lay_x   = '{50, 300, 150, 400, 250, 100, 350};
    lay_y   = '{10, 70, 130, 190, 250, 310, 370};
    lay_len = '{10, 10, 10, 10, 10, 10, 10};
end

`endif

/* common/jump_pkg.sv */
// Shared sizes and constants for the vertical-scroller core
// World geometry, physics tuning and platform field widths

`default_nettype none

package jump_pkg;

    // World coordinates
    localparam int PHY_WIDTH       = 16;
    localparam int BLOCK_HEIGHT    = 480;
    localparam int CAMERA_WIDTH    = 6;

    // Segment layouts
    localparam int BLOCK_NUM       = 7;
    localparam int BLOCK_IDX_WIDTH = 3;
    localparam int PLAT_NUM        = 7;

    // Platform length in 8-pixel units
    localparam int LEN_WIDTH       = 4;
    localparam int PLAT_UNIT       = 8;

    // Signed velocity, pixels per tick
    localparam int VEL_WIDTH       = 6;
    localparam int JUMP_VEL        = 8;
    localparam int GRAVITY         = 1;
    localparam int MAX_FALL        = 8;

endpackage

`default_nettype wire

/* common/plat_if.sv */
// Platform set of the current level segment
// Driven by the segment generator, read by the landing detector

`timescale 1ns/1ps
`default_nettype none

interface plat_if;
    import jump_pkg::*;

    // Entry 0 sits in the low bits of each array
    logic [PLAT_NUM-1:0][PHY_WIDTH-1:0] plat_x;
    logic [PLAT_NUM-1:0][PHY_WIDTH-1:0] plat_y;
    logic [PLAT_NUM-1:0][LEN_WIDTH-1:0] plat_len;
    logic [PHY_WIDTH-1:0]               base_y;

    modport src (
        output plat_x,
        output plat_y,
        output plat_len,
        output base_y
    );

    modport dst (
        input plat_x,
        input plat_y,
        input plat_len,
        input base_y
    );

endinterface

`default_nettype wire

/* hw/level/block_gen.sv */
// Level-segment generator
// Tracks the camera row of the character, selects the block layout
// and flags row switches with their direction

`timescale 1ns/1ps
`default_nettype none

module block_gen (
    input  logic                                  sys_clk,
    input  logic                                  sys_rst_n,
    input  logic [jump_pkg::PHY_WIDTH-1:0]        char_y,
    output logic [jump_pkg::CAMERA_WIDTH-1:0]     camera_y,
    output logic [jump_pkg::BLOCK_IDX_WIDTH-1:0]  block_type,
    output logic                                  block_switch,
    output logic                                  switch_up,
    plat_if.src                                   plat
);
    import jump_pkg::*;

    logic [PHY_WIDTH-1:0]       cur_row;
    logic [PHY_WIDTH-1:0]       row_q;
    logic [PHY_WIDTH-1:0]       prev_row;
    logic [BLOCK_IDX_WIDTH-1:0] prev_block;
    logic                       block_changed;

    logic [PHY_WIDTH-1:0] lay_x   [PLAT_NUM];
    logic [PHY_WIDTH-1:0] lay_y   [PLAT_NUM];
    logic [LEN_WIDTH-1:0] lay_len [PLAT_NUM];

    assign cur_row = char_y / PHY_WIDTH'(BLOCK_HEIGHT);

    // Row register, camera output is its low bits
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            row_q      <= '0;
            block_type <= '0;
        end else begin
            row_q      <= cur_row;
            block_type <= BLOCK_IDX_WIDTH'(cur_row % PHY_WIDTH'(BLOCK_NUM));
        end
    end

    assign camera_y = row_q[CAMERA_WIDTH-1:0];

    assign block_changed = (block_type != prev_block);

    // Switch pulse lands one cycle after block_type moves
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            prev_block   <= '0;
            prev_row     <= '0;
            block_switch <= 1'b0;
            switch_up    <= 1'b0;
        end else begin
            prev_block   <= block_type;
            prev_row     <= row_q;
            block_switch <= block_changed;
            // Direction holds until the next block change
            if (block_changed) begin
                switch_up <= (row_q > prev_row);
            end
        end
    end

    // Row base height of the current segment
    assign plat.base_y = PHY_WIDTH'(row_q * PHY_WIDTH'(BLOCK_HEIGHT));

    always_comb begin
        case (block_type)
`include "level_layout.svh"
            default: begin
                lay_x   = '{default: '0};
                lay_y   = '{default: '0};
                lay_len = '{default: '0};
            end
        endcase

        for (int i = 0; i < PLAT_NUM; i++) begin
            plat.plat_x[i]   = lay_x[i];
            plat.plat_y[i]   = lay_y[i];
            plat.plat_len[i] = lay_len[i];
        end
    end

endmodule

`default_nettype wire

/* hw/physics/char_physics.sv */
// Character physics
// Holds height, velocity and grounded state, stepping once per frame tick
// with spawn, jump, gravity and landing snap

`timescale 1ns/1ps
`default_nettype none

module char_physics (
    input  logic                                 sys_clk,
    input  logic                                 sys_rst_n,
    input  logic                                 tick,
    input  logic                                 jump,
    input  logic                                 spawn,
    input  logic [jump_pkg::PHY_WIDTH-1:0]       spawn_y,
    output logic [jump_pkg::PHY_WIDTH-1:0]       next_y,
    output logic signed [jump_pkg::VEL_WIDTH-1:0] vel,
    input  logic                                 land_hit,
    input  logic [jump_pkg::PHY_WIDTH-1:0]       land_y,
    output logic [jump_pkg::PHY_WIDTH-1:0]       char_y,
    output logic                                 grounded
);
    import jump_pkg::*;

    logic signed [PHY_WIDTH+1:0] y_sum;
    logic signed [VEL_WIDTH:0]   vel_sub;
    logic signed [VEL_WIDTH-1:0] vel_next;

    // Proposed height, clamped at the floor
    assign y_sum  = $signed({2'b00, char_y}) + vel;
    assign next_y = y_sum[PHY_WIDTH+1] ? '0 : y_sum[PHY_WIDTH-1:0];

    // Gravity with terminal falling speed
    assign vel_sub  = vel - (VEL_WIDTH+1)'(GRAVITY);
    assign vel_next = (vel_sub < -(VEL_WIDTH+1)'(MAX_FALL)) ?
                      -VEL_WIDTH'(MAX_FALL) : vel_sub[VEL_WIDTH-1:0];

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            char_y   <= '0;
            vel      <= '0;
            grounded <= 1'b1;
        end else if (spawn) begin
            char_y   <= spawn_y;
            vel      <= '0;
            grounded <= 1'b0;
        end else if (tick) begin
            if (grounded) begin
                // Standing still unless a jump starts
                if (jump) begin
                    vel      <= VEL_WIDTH'(JUMP_VEL);
                    grounded <= 1'b0;
                end
            end else if (land_hit) begin
                char_y   <= land_y;
                vel      <= '0;
                grounded <= 1'b1;
            end else if (next_y == '0) begin
                char_y   <= '0;
                vel      <= '0;
                grounded <= 1'b1;
            end else begin
                char_y <= next_y;
                vel    <= vel_next;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/physics/land_detect.sv */
// Landing detector
// Tests the falling character against every platform of the current segment
// and reports the highest platform top crossed this tick

`timescale 1ns/1ps
`default_nettype none

module land_detect (
    input  logic [jump_pkg::PHY_WIDTH-1:0]        char_x,
    input  logic [jump_pkg::PHY_WIDTH-1:0]        char_y,
    input  logic [jump_pkg::PHY_WIDTH-1:0]        next_y,
    input  logic signed [jump_pkg::VEL_WIDTH-1:0] vel,
    plat_if.dst                                   plat,
    output logic                                  land_hit,
    output logic [jump_pkg::PHY_WIDTH-1:0]        land_y
);
    import jump_pkg::*;

    logic                 falling;
    logic [PLAT_NUM-1:0]  hit;
    logic [PHY_WIDTH-1:0] top   [PLAT_NUM];
    logic [PHY_WIDTH-1:0] x_end [PLAT_NUM];

    // Zero velocity counts as falling
    assign falling = vel[VEL_WIDTH-1] || (vel == '0);

    always_comb begin
        for (int i = 0; i < PLAT_NUM; i++) begin
            top[i]   = plat.base_y + plat.plat_y[i];
            x_end[i] = plat.plat_x[i] + PHY_WIDTH'(plat.plat_len[i] * PLAT_UNIT);
            // Top passed between this height and the next one
            hit[i]   = falling
                       && (next_y <= top[i]) && (top[i] <= char_y)
                       && (char_x >= plat.plat_x[i]) && (char_x < x_end[i]);
        end
    end

    // Highest crossed top wins
    always_comb begin
        land_y = '0;
        for (int i = 0; i < PLAT_NUM; i++) begin
            if (hit[i] && (top[i] > land_y)) begin
                land_y = top[i];
            end
        end
    end

    assign land_hit = |hit;

endmodule

`default_nettype wire

/* hw/jump_top.sv */
// Vertical-scroller core top level
// Connects character physics, landing detector and segment generator

`timescale 1ns/1ps
`default_nettype none

module jump_top (
    input  logic                                              sys_clk,
    input  logic                                              sys_rst_n,
    input  logic                                              tick,
    input  logic                                              jump,
    input  logic                                              spawn,
    input  logic [jump_pkg::PHY_WIDTH-1:0]                    spawn_y,
    input  logic [jump_pkg::PHY_WIDTH-1:0]                    char_x,
    output logic [jump_pkg::PHY_WIDTH-1:0]                    char_y,
    output logic                                              grounded,
    output logic [jump_pkg::CAMERA_WIDTH-1:0]                 camera_y,
    output logic [jump_pkg::BLOCK_IDX_WIDTH-1:0]              block_type,
    output logic                                              block_switch,
    output logic                                              switch_up,
    output logic [jump_pkg::PLAT_NUM*jump_pkg::PHY_WIDTH-1:0] plat_x,
    output logic [jump_pkg::PLAT_NUM*jump_pkg::PHY_WIDTH-1:0] plat_y,
    output logic [jump_pkg::PLAT_NUM*jump_pkg::LEN_WIDTH-1:0] plat_len
);
    import jump_pkg::*;

    logic [PHY_WIDTH-1:0]        next_y;
    logic signed [VEL_WIDTH-1:0] vel;
    logic                        land_hit;
    logic [PHY_WIDTH-1:0]        land_y;

    plat_if plat ();

    char_physics u_physics (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .tick      (tick),
        .jump      (jump),
        .spawn     (spawn),
        .spawn_y   (spawn_y),
        .next_y    (next_y),
        .vel       (vel),
        .land_hit  (land_hit),
        .land_y    (land_y),
        .char_y    (char_y),
        .grounded  (grounded)
    );

    land_detect u_land (
        .char_x   (char_x),
        .char_y   (char_y),
        .next_y   (next_y),
        .vel      (vel),
        .plat     (plat.dst),
        .land_hit (land_hit),
        .land_y   (land_y)
    );

    block_gen u_block (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .char_y       (char_y),
        .camera_y     (camera_y),
        .block_type   (block_type),
        .block_switch (block_switch),
        .switch_up    (switch_up),
        .plat         (plat.src)
    );

    // Platform 0 in the low bits
    assign plat_x   = plat.plat_x;
    assign plat_y   = plat.plat_y;
    assign plat_len = plat.plat_len;

endmodule

`default_nettype wire

/* sim/jump_sva.sv */
// Assertions for the scroller core
// Row-switch pulse shape and grounded state, bound to the top level

`timescale 1ns/1ps
`default_nettype none

module jump_sva (
    input logic                                  sys_clk,
    input logic                                  sys_rst_n,
    input logic                                  grounded,
    input logic signed [jump_pkg::VEL_WIDTH-1:0] vel,
    input logic [jump_pkg::BLOCK_IDX_WIDTH-1:0]  block_type,
    input logic                                  block_switch,
    input logic                                  switch_up
);
    int unsigned fail_count = 0;

    // Pulse lasts a single cycle
    assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        block_switch |=> !block_switch)
        else begin
            fail_count++;
            $error("block_switch high for more than one cycle");
        end

    // Every block change is followed by a pulse
    assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        $changed(block_type) |=> block_switch)
        else begin
            fail_count++;
            $error("block_type changed without a block_switch pulse");
        end

    // Direction only moves together with the pulse
    assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        !block_switch |-> $stable(switch_up))
        else begin
            fail_count++;
            $error("switch_up moved without a block_switch pulse");
        end

    assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        grounded |-> (vel == '0))
        else begin
            fail_count++;
            $error("grounded with nonzero velocity");
        end

endmodule

`default_nettype wire

/* sim/jump_tb.sv */
// Testbench for the scroller core
// Spawns the character in several rows, checks segment outputs, landing and jump

`timescale 1ns/1ps
`default_nettype none

module jump_tb;
    import jump_pkg::*;

    localparam int NROWS = 11;
    localparam int RND = -1;
    localparam int JUMP_PEAK = 36;
    localparam int LAND_LIMIT = 150;

    // spawn_y, char_x (RND draws one), jump, expected block, expected landing y
    int tab [NROWS][5] = '{
        '{100, 120, 0, 0, 80},
        '{680, 120, 0, 1, 670},
        '{1740, 360, 0, 3, 1640},
        '{1230, 320, 0, 2, 1155},
        '{0, RND, 1, 0, 0},
        '{3450, 130, 0, 0, 3440},
        '{150, 10, 0, 0, 0},
        '{2070, 60, 0, 4, 2060},
        '{2500, 420, 0, 5, 2415},
        '{3200, 110, 0, 6, 3190},
        '{0, RND, 1, 0, 0}
    };

    // Segment layouts indexed as [block][platform]
    int lay_x [7][7] = '{
        '{280, 100, 350, 50, 300, 150, 400}, '{450, 50, 400, 100, 350, 150, 450},
        '{300, 200, 100, 300, 200, 100, 300}, '{400, 350, 400, 350, 400, 350, 400},
        '{50, 100, 50, 100, 50, 100, 50}, '{400, 100, 350, 150, 300, 200, 400},
        '{50, 300, 150, 400, 250, 100, 350}
    };
    int lay_y [7][7] = '{
        '{60, 80, 140, 200, 260, 320, 380}, '{10, 70, 130, 190, 250, 310, 370},
        '{15, 75, 135, 195, 255, 315, 375}, '{20, 80, 140, 200, 260, 320, 380},
        '{20, 80, 140, 200, 260, 320, 380}, '{15, 75, 135, 195, 255, 315, 375},
        '{10, 70, 130, 190, 250, 310, 370}
    };
    int lay_len [7][7] = '{
        '{10, 8, 8, 8, 8, 8, 8}, '{5, 5, 5, 5, 5, 5, 5}, '{6, 6, 6, 6, 6, 6, 6},
        '{8, 8, 8, 8, 8, 8, 8}, '{8, 8, 8, 5, 10, 5, 8}, '{10, 10, 10, 8, 8, 8, 10},
        '{10, 10, 10, 10, 10, 10, 10}
    };

    logic                       sys_clk;
    logic                       sys_rst_n;
    logic                       tick;
    logic                       jump;
    logic                       spawn;
    logic [PHY_WIDTH-1:0]       spawn_y;
    logic [PHY_WIDTH-1:0]       char_x;
    logic [PHY_WIDTH-1:0]       char_y;
    logic                       grounded;
    logic [CAMERA_WIDTH-1:0]    camera_y;
    logic [BLOCK_IDX_WIDTH-1:0] block_type;
    logic                       block_switch;
    logic                       switch_up;
    logic [PLAT_NUM*PHY_WIDTH-1:0] plat_x;
    logic [PLAT_NUM*PHY_WIDTH-1:0] plat_y;
    logic [PLAT_NUM*LEN_WIDTH-1:0] plat_len;

    integer seed;
    int     errors;
    int     tests_failed;
    int     prev_blk;
    int     prev_row;
    logic   exp_up;

    jump_top dut (.*);

    bind jump_top jump_sva u_sva (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .grounded     (grounded),
        .vel          (vel),
        .block_type   (block_type),
        .block_switch (block_switch),
        .switch_up    (switch_up)
    );

    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;
    end

    initial begin
        repeat (NROWS * 200) @(posedge sys_clk);
        $display("Watchdog expired before all tests finished");
        $display("Result: FAILED");
        $finish;
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %0h expected %0h", name, got, exp);
        end
    endtask

    task automatic check_layout(input int blk);
        for (int i = 0; i < PLAT_NUM; i++) begin
            compare($sformatf("plat_x[%0d]", i), plat_x[i*PHY_WIDTH +: PHY_WIDTH], lay_x[blk][i]);
            compare($sformatf("plat_y[%0d]", i), plat_y[i*PHY_WIDTH +: PHY_WIDTH], lay_y[blk][i]);
            compare($sformatf("plat_len[%0d]", i), plat_len[i*LEN_WIDTH +: LEN_WIDTH],
                    lay_len[blk][i]);
        end
    endtask

    // Jump from the floor tracked against a step model of the motion rules
    task automatic fly_jump();
        int ry;
        int rv;
        int ny;
        int peak;
        int steps;
        logic rg;
        jump = 1'b1;
        @(negedge sys_clk);
        ry = 0;
        rv = JUMP_VEL;
        rg = 1'b0;
        peak = 0;
        steps = 0;
        while (!rg && steps < LAND_LIMIT) begin
            // Strobe while airborne must not disturb the flight
            jump = (steps == 2);
            ny = ry + rv;
            if (ny <= 0) begin
                ry = 0;
                rv = 0;
                rg = 1'b1;
            end else begin
                ry = ny;
                rv = (rv - GRAVITY < -MAX_FALL) ? -MAX_FALL : rv - GRAVITY;
            end
            @(negedge sys_clk);
            compare("char_y", char_y, ry);
            compare("grounded", grounded, rg);
            if (char_y > peak) peak = char_y;
            steps++;
        end
        jump = 1'b0;
        compare("jump peak", peak, JUMP_PEAK);
    endtask

    task automatic run_row(input int idx);
        int sy;
        int cx;
        int row;
        int blk;
        int wait_cnt;
        int err_start;
        logic changed;
        err_start = errors;
        sy = tab[idx][0];
        cx = tab[idx][1];
        if (cx < 0) cx = $random(seed) & 32'h01ff;
        row = sy / BLOCK_HEIGHT;
        blk = tab[idx][3];
        changed = (blk != prev_blk);
        if (changed) exp_up = (row > prev_row);
        // Ticks held off until the segment has followed the spawn
        tick = 1'b0;
        spawn = 1'b1;
        spawn_y = sy;
        char_x = cx;
        @(negedge sys_clk);
        spawn = 1'b0;
        @(negedge sys_clk);
        compare("camera_y", camera_y, row);
        compare("block_type", block_type, blk);
        compare("block_switch", block_switch, 1'b0);
        check_layout(blk);
        tick = 1'b1;
        @(negedge sys_clk);
        compare("block_switch", block_switch, changed);
        compare("switch_up", switch_up, exp_up);
        @(negedge sys_clk);
        compare("block_switch", block_switch, 1'b0);
        wait_cnt = 0;
        while (!grounded && wait_cnt < LAND_LIMIT) begin
            @(negedge sys_clk);
            compare("block_switch", block_switch, 1'b0);
            wait_cnt++;
        end
        if (!grounded) begin
            errors++;
            $display("Character never landed in test %0d", idx);
        end
        if (tab[idx][2] != 0) fly_jump();
        compare("char_y", char_y, tab[idx][4]);
        compare("grounded", grounded, 1'b1);
        prev_blk = blk;
        prev_row = row;
        if (errors != err_start) tests_failed++;
        $display("Test %0d spawn_y=%0d char_x=%0d jump=%0d: %s", idx, sy, cx, tab[idx][2],
                 (errors == err_start) ? "ok" : "errors");
    endtask

    initial begin
        seed = 32'h74e56b23;
        errors = 0;
        tests_failed = 0;
        prev_blk = 0;
        prev_row = 0;
        exp_up = 1'b0;
        sys_rst_n = 1'b0;
        tick = 1'b0;
        jump = 1'b0;
        spawn = 1'b0;
        spawn_y = '0;
        char_x = '0;
        repeat (3) @(posedge sys_clk);
        @(negedge sys_clk);
        sys_rst_n = 1'b1;
        @(negedge sys_clk);
        compare("char_y", char_y, 0);
        compare("grounded", grounded, 1'b1);
        compare("camera_y", camera_y, 0);
        compare("block_type", block_type, 0);
        compare("block_switch", block_switch, 1'b0);
        compare("switch_up", switch_up, 1'b0);
        check_layout(0);
        if (errors != 0) tests_failed++;
        $display("Test reset: %s", (errors == 0) ? "ok" : "errors");
        for (int i = 0; i < NROWS; i++) begin
            run_row(i);
        end
        errors += dut.u_sva.fail_count;
        $display("Tests %0d, failed %0d, check errors %0d", NROWS + 1, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+hw/level
common/jump_pkg.sv
common/plat_if.sv
hw/level/block_gen.sv
hw/physics/char_physics.sv
hw/physics/land_detect.sv
hw/jump_top.sv
sim/jump_sva.sv
sim/jump_tb.sv
